// File: hw/icache_pkg.sv
/* Instruction cache shared definitions */

package icache_pkg;

    localparam int ADDR_W   = 32;
    localparam int INST_W   = 32;
    localparam int LINE_W   = 64;
    localparam int INDEX_W  = 6;
    localparam int TAG_W    = 23;
    localparam int NUM_SETS = 1 << INDEX_W;

    // A fetch address seen as its cache fields, from the top bit down.
    typedef struct packed {
        logic [TAG_W-1:0]   tag;
        logic [INDEX_W-1:0] index;
        logic               word_sel;  // picks the high word of the line when set.
        logic [1:0]         byte_off;
    } fetch_addr_t;

    // Result of the tag compare, one cycle after the index.
    typedef struct packed {
        logic       hit;
        logic       hit_way;
        logic [1:0] way_valid;
    } lookup_t;

    // Refill write into one way of both arrays.
    typedef struct packed {
        logic we;
        logic way;
    } fill_t;

    typedef enum logic [1:0] {
        IDLE,
        CHECK,
        REFILL,
        FENCE
    } state_t;

endpackage

// File: hw/icache_ctrl.sv
/* Instruction cache control */

`timescale 1ns/1ps

module icache_ctrl (
    input  logic                          clk,
    input  logic                          reset_i,
    input  logic                          fetch_req_i,
    input  icache_pkg::fetch_addr_t       fetch_addr_i,
    input  logic                          fence_i,
    input  logic                          mem_valid_i,
    input  icache_pkg::lookup_t           lookup_i,
    input  logic                          victim_way_i,
    output logic [icache_pkg::INDEX_W-1:0] array_index_o,
    output icache_pkg::fill_t             fill_o,
    output logic                          fetch_valid_o,
    output logic                          mem_read_o,
    output logic [icache_pkg::ADDR_W-1:0] mem_addr_o,
    output logic                          touch_o,
    output logic                          served_o
);

    icache_pkg::state_t state_q;
    icache_pkg::state_t state_d;

    // one bit wider than the index so the sweep can stop after the last set.
    logic [icache_pkg::INDEX_W:0] sweep_q;
    logic                         victim_q;
    logic                         hit_now;

    icache_pkg::fetch_addr_t line_addr;

    assign hit_now = (state_q == icache_pkg::CHECK) && lookup_i.hit;

    always_comb begin
        state_d = state_q;
        case (state_q)
            icache_pkg::IDLE: begin
                if (fence_i) begin
                    state_d = icache_pkg::FENCE;
                end else if (fetch_req_i) begin
                    state_d = icache_pkg::CHECK;
                end
            end
            icache_pkg::CHECK: begin
                if (lookup_i.hit) begin
                    state_d = icache_pkg::IDLE;
                end else begin
                    state_d = icache_pkg::REFILL;
                end
            end
            icache_pkg::REFILL: begin
                if (mem_valid_i) begin
                    state_d = icache_pkg::IDLE;  // the lookup is repeated on the filled line.
                end
            end
            icache_pkg::FENCE: begin
                if (!fence_i) begin
                    state_d = icache_pkg::IDLE;
                end
            end
            default: begin
                state_d = icache_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= icache_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i || (state_q != icache_pkg::FENCE)) begin
            sweep_q <= '0;
        end else if (!sweep_q[icache_pkg::INDEX_W]) begin
            sweep_q <= sweep_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if ((state_q == icache_pkg::CHECK) && !lookup_i.hit) begin
            victim_q <= victim_way_i;  // held for the whole refill.
        end
    end

    always_comb begin
        line_addr          = fetch_addr_i;
        line_addr.word_sel = 1'b0;
        line_addr.byte_off = 2'b00;
    end

    assign array_index_o = (state_q == icache_pkg::FENCE) ?
                           sweep_q[icache_pkg::INDEX_W-1:0] : fetch_addr_i.index;

    assign fill_o.we  = (state_q == icache_pkg::REFILL) && mem_valid_i;
    assign fill_o.way = victim_q;

    assign mem_read_o = (state_q == icache_pkg::REFILL);
    assign mem_addr_o = line_addr;

    assign fetch_valid_o = hit_now;
    assign touch_o       = hit_now;
    assign served_o      = fetch_valid_o;

endmodule

// File: hw/icache_tag_array.sv
/* Instruction cache tag array */

`timescale 1ns/1ps

module icache_tag_array (
    input  logic                           clk,
    input  logic                           reset_i,
    input  logic [icache_pkg::INDEX_W-1:0] array_index_i,
    input  logic [icache_pkg::TAG_W-1:0]   tag_i,
    input  icache_pkg::fill_t              fill_i,
    input  logic                           fence_clear_i,
    output icache_pkg::lookup_t            lookup_o
);

    logic [icache_pkg::TAG_W-1:0] tag_mem [icache_pkg::NUM_SETS][2];
    logic [1:0]                   valid_q [icache_pkg::NUM_SETS];

    logic [icache_pkg::TAG_W-1:0] rd_tag_q [2];
    logic [1:0]                   rd_valid_q;
    logic [1:0]                   way_match;

    always_ff @(posedge clk) begin
        rd_tag_q[0] <= tag_mem[array_index_i][0];
        rd_tag_q[1] <= tag_mem[array_index_i][1];
        if (fill_i.we) begin
            tag_mem[array_index_i][fill_i.way] <= tag_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int s = 0; s < icache_pkg::NUM_SETS; s++) begin
                valid_q[s] <= 2'b00;
            end
            rd_valid_q <= 2'b00;
        end else begin
            rd_valid_q <= valid_q[array_index_i];  // read sees the old value on a write edge.
            if (fill_i.we) begin
                valid_q[array_index_i][fill_i.way] <= 1'b1;
            end
            if (fence_clear_i) begin
                valid_q[array_index_i] <= 2'b00;  // a fence drops even a fill in flight.
            end
        end
    end

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_match[w] = rd_valid_q[w] && (rd_tag_q[w] == tag_i);
        end
    end

    assign lookup_o.hit       = |way_match;
    assign lookup_o.hit_way   = way_match[1];
    assign lookup_o.way_valid = rd_valid_q;

endmodule

// File: hw/icache_data_array.sv
/* Instruction cache line storage */

`timescale 1ns/1ps

module icache_data_array (
    input  logic                           clk,
    input  logic [icache_pkg::INDEX_W-1:0] index_i,
    input  logic                           word_sel_i,
    input  icache_pkg::fill_t              fill_i,
    input  logic [icache_pkg::LINE_W-1:0]  mem_data_i,
    input  icache_pkg::lookup_t            lookup_i,
    output logic [icache_pkg::INST_W-1:0]  inst_o
);

    logic [icache_pkg::LINE_W-1:0] line_mem [icache_pkg::NUM_SETS][2];
    logic [icache_pkg::LINE_W-1:0] rd_line_q [2];
    logic [icache_pkg::LINE_W-1:0] hit_line;

    always_ff @(posedge clk) begin
        rd_line_q[0] <= line_mem[index_i][0];
        rd_line_q[1] <= line_mem[index_i][1];
        if (fill_i.we) begin
            line_mem[index_i][fill_i.way] <= mem_data_i;
        end
    end

    assign hit_line = rd_line_q[lookup_i.hit_way];

    // word select 0 takes the low half of the line.
    assign inst_o = hit_line[word_sel_i*icache_pkg::INST_W +: icache_pkg::INST_W];

endmodule

// File: hw/icache_replace.sv
/* Age based victim choice */

`timescale 1ns/1ps

module icache_replace #(
    parameter int AGE_W = 3
) (
    input  logic                           clk,
    input  logic                           reset_i,
    input  logic [icache_pkg::INDEX_W-1:0] index_i,
    input  icache_pkg::lookup_t            lookup_i,
    input  logic                           touch_i,
    input  logic                           served_i,
    input  icache_pkg::fill_t              fill_i,
    output logic                           victim_way_o
);

    localparam logic [AGE_W-1:0] AGE_MAX = '1;

    logic [AGE_W-1:0] age_q [icache_pkg::NUM_SETS][2];
    logic [AGE_W-1:0] age_way0;
    logic [AGE_W-1:0] age_way1;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int s = 0; s < icache_pkg::NUM_SETS; s++) begin
                age_q[s][0] <= '0;
                age_q[s][1] <= '0;
            end
        end else begin
            if (served_i) begin
                for (int s = 0; s < icache_pkg::NUM_SETS; s++) begin
                    for (int w = 0; w < 2; w++) begin
                        if (age_q[s][w] != AGE_MAX) begin
                            age_q[s][w] <= age_q[s][w] + 1'b1;
                        end
                    end
                end
            end
            // the used way restarts from zero after the general aging.
            if (touch_i) begin
                age_q[index_i][lookup_i.hit_way] <= '0;
            end
            if (fill_i.we) begin
                age_q[index_i][fill_i.way] <= '0;
            end
        end
    end

    assign age_way0 = age_q[index_i][0];
    assign age_way1 = age_q[index_i][1];

    always_comb begin
        if (!lookup_i.way_valid[0]) begin
            victim_way_o = 1'b0;
        end else if (!lookup_i.way_valid[1]) begin
            victim_way_o = 1'b1;
        end else begin
            victim_way_o = (age_way1 > age_way0);  // ties go to way 0.
        end
    end

endmodule

// File: hw/icache_top.sv
/* Two way instruction cache */

`timescale 1ns/1ps

module icache_top #(
    parameter int AGE_W = 3
) (
    input  logic                          clk,
    input  logic                          reset_i,
    input  logic                          fetch_req_i,
    input  icache_pkg::fetch_addr_t       fetch_addr_i,
    output logic                          fetch_valid_o,
    output logic [icache_pkg::INST_W-1:0] fetch_inst_o,
    output logic                          mem_read_o,
    output logic [icache_pkg::ADDR_W-1:0] mem_addr_o,
    input  logic                          mem_valid_i,
    input  logic [icache_pkg::LINE_W-1:0] mem_data_i,
    input  logic                          fence_i
);

    logic [icache_pkg::INDEX_W-1:0] array_index;
    icache_pkg::fill_t              fill;
    icache_pkg::lookup_t            lookup;
    logic                           victim_way;
    logic                           touch;
    logic                           served;

    icache_ctrl u_ctrl (
        .clk           (clk),
        .reset_i       (reset_i),
        .fetch_req_i   (fetch_req_i),
        .fetch_addr_i  (fetch_addr_i),
        .fence_i       (fence_i),
        .mem_valid_i   (mem_valid_i),
        .lookup_i      (lookup),
        .victim_way_i  (victim_way),
        .array_index_o (array_index),
        .fill_o        (fill),
        .fetch_valid_o (fetch_valid_o),
        .mem_read_o    (mem_read_o),
        .mem_addr_o    (mem_addr_o),
        .touch_o       (touch),
        .served_o      (served)
    );

    // valid bits of the presented set drop for as long as the fence is held.
    icache_tag_array u_tag_array (
        .clk           (clk),
        .reset_i       (reset_i),
        .array_index_i (array_index),
        .tag_i         (fetch_addr_i.tag),
        .fill_i        (fill),
        .fence_clear_i (fence_i),
        .lookup_o      (lookup)
    );

    icache_data_array u_data_array (
        .clk        (clk),
        .index_i    (array_index),
        .word_sel_i (fetch_addr_i.word_sel),
        .fill_i     (fill),
        .mem_data_i (mem_data_i),
        .lookup_i   (lookup),
        .inst_o     (fetch_inst_o)
    );

    icache_replace #(
        .AGE_W (AGE_W)
    ) u_replace (
        .clk          (clk),
        .reset_i      (reset_i),
        .index_i      (array_index),
        .lookup_i     (lookup),
        .touch_i      (touch),
        .served_i     (served),
        .fill_i       (fill),
        .victim_way_o (victim_way)
    );

endmodule

// File: test/icache_chk.sv
/* Cache port assertions */

`timescale 1ns/1ps

module icache_chk (
    input logic                          clk,
    input logic                          reset_i,
    input logic                          fetch_valid_i,
    input logic                          mem_read_i,
    input logic [icache_pkg::ADDR_W-1:0] mem_addr_i,
    input logic                          mem_valid_i
);

    // a served fetch is a single cycle pulse.
    valid_pulse: assert property (@(posedge clk) disable iff (reset_i)
        fetch_valid_i |=> !fetch_valid_i)
        else $error("fetch_valid_o stayed high for two cycles");

    line_aligned: assert property (@(posedge clk) disable iff (reset_i)
        mem_read_i |-> (mem_addr_i[2:0] == 3'b000))
        else $error("mem_addr_o is not line aligned during a read");

    // the read level only ends in the cycle after the response.
    read_held: assert property (@(posedge clk) disable iff (reset_i)
        (mem_read_i && !mem_valid_i) |=> mem_read_i)
        else $error("mem_read_o dropped before mem_valid_i");

endmodule

// File: test/icache_tb.sv
/* Instruction cache testbench */

`timescale 1ns/1ps

module icache_tb;

    localparam int          AGE_W      = 3;
    localparam int          AGE_MAX    = (1 << AGE_W) - 1;
    localparam int          WAIT_LIMIT = 50;
    localparam logic [31:0] DATA_KEY   = 32'hA5C3_0F96;
    localparam logic [22:0] TAG_BASE   = 23'h2D4C0;

    logic                    clk = 1'b0;
    logic                    reset_i;
    logic                    fetch_req_i;
    icache_pkg::fetch_addr_t fetch_addr_i;
    logic                    fetch_valid_o;
    logic [31:0]             fetch_inst_o;
    logic                    mem_read_o;
    logic [31:0]             mem_addr_o;
    logic                    mem_valid_i;
    logic [63:0]             mem_data_i;
    logic                    fence_i;

    logic [15:0] lfsr_q = 16'd44;
    int          n_checks;
    int          n_errors;
    int          n_timeouts;
    bit          timed_out;
    bit          read_seen;

    // reference copy of the cache state.
    logic [22:0] m_tag [64][2];
    bit          m_valid [64][2];
    int          m_age [64][2];

    always #20 clk = ~clk;

    icache_top #(
        .AGE_W (AGE_W)
    ) u_dut (
        .clk           (clk),
        .reset_i       (reset_i),
        .fetch_req_i   (fetch_req_i),
        .fetch_addr_i  (fetch_addr_i),
        .fetch_valid_o (fetch_valid_o),
        .fetch_inst_o  (fetch_inst_o),
        .mem_read_o    (mem_read_o),
        .mem_addr_o    (mem_addr_o),
        .mem_valid_i   (mem_valid_i),
        .mem_data_i    (mem_data_i),
        .fence_i       (fence_i)
    );

    bind icache_top icache_chk u_chk (
        .clk           (clk),
        .reset_i       (reset_i),
        .fetch_valid_i (fetch_valid_o),
        .mem_read_i    (mem_read_o),
        .mem_addr_i    (mem_addr_o),
        .mem_valid_i   (mem_valid_i)
    );

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value  = {value[30:0], lfsr_q[0]};
            lfsr_q = {1'b0, lfsr_q[15:1]} ^ (lfsr_q[0] ? 16'hB400 : 16'h0000);
        end
        return value;
    endfunction

    function automatic logic [31:0] make_addr(input logic [22:0] tag, input logic [5:0] index,
                                              input logic word_sel);
        icache_pkg::fetch_addr_t fa;
        fa.tag      = tag;
        fa.index    = index;
        fa.word_sel = word_sel;
        fa.byte_off = 2'b00;
        return fa;
    endfunction

    // four tags over four sets, so two ways keep overflowing.
    function automatic logic [31:0] pool_addr();
        logic [31:0] tag_r;
        logic [31:0] index_r;
        logic [31:0] word_r;
        tag_r   = take_bits(2);
        index_r = take_bits(2);
        word_r  = take_bits(1);
        return make_addr(TAG_BASE + tag_r[22:0], 6'd20 + index_r[5:0], word_r[0]);
    endfunction

    function automatic bit model_hit(input icache_pkg::fetch_addr_t fa, output bit way);
        way = 1'b0;
        for (int w = 0; w < 2; w++) begin
            if (m_valid[fa.index][w] && (m_tag[fa.index][w] == fa.tag)) begin
                way = (w == 1);
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    function automatic bit model_victim(input logic [5:0] index);
        if (!m_valid[index][0]) begin
            return 1'b0;
        end else if (!m_valid[index][1]) begin
            return 1'b1;
        end
        return m_age[index][1] > m_age[index][0];
    endfunction

    function automatic void model_serve(input logic [5:0] index, input bit way);
        for (int s = 0; s < 64; s++) begin
            for (int w = 0; w < 2; w++) begin
                if (m_age[s][w] < AGE_MAX) begin
                    m_age[s][w]++;
                end
            end
        end
        m_age[index][way] = 0;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        n_checks++;
        if (got !== expected) begin
            n_errors++;
            $display("Error at %0t: %s is %0h, expected %0h", $time, name, got, expected);
        end
    endtask

    task automatic wait_for(input bit for_read, input string what, output int cycles);
        bit done;
        cycles    = 0;
        done      = 1'b0;
        read_seen = 1'b0;
        while (!done && (cycles < WAIT_LIMIT)) begin
            @(negedge clk);
            if (mem_read_o) begin
                read_seen = 1'b1;
            end
            if (for_read ? mem_read_o : fetch_valid_o) begin
                done = 1'b1;
            end else begin
                cycles++;
            end
        end
        if (!done) begin
            n_timeouts++;
            timed_out = 1'b1;
            $display("Timeout at %0t: no %s within %0d cycles", $time, what, WAIT_LIMIT);
        end
    endtask

    // one request from IDLE up to its response, memory side included.
    task automatic fetch(input logic [31:0] addr);
        icache_pkg::fetch_addr_t fa;
        bit                      exp_hit;
        bit                      way;
        int                      cycles;
        int                      delay;
        logic [31:0]             line_base;
        logic [31:0]             exp_inst;
        if (timed_out) return;
        fa        = addr;
        line_base = {addr[31:3], 3'b000};
        exp_inst  = {addr[31:2], 2'b00} ^ DATA_KEY;
        exp_hit   = model_hit(fa, way);
        if (!exp_hit) begin
            way = model_victim(fa.index);
        end
        fetch_req_i  = 1'b1;
        fetch_addr_i = fa;
        if (!exp_hit) begin
            wait_for(1'b1, "memory read", cycles);
            if (timed_out) return;
            check_value("mem_read_o delay", 64'(cycles), 64'd2);
            check_value("mem_addr_o", 64'(mem_addr_o), 64'(line_base));
            delay = take_bits(3) % 6;
            repeat (delay + 1) begin
                @(posedge clk);
                #1;
            end
            mem_valid_i = 1'b1;
            mem_data_i  = {(line_base + 32'd4) ^ DATA_KEY, line_base ^ DATA_KEY};
            @(posedge clk);
            #1;
            mem_valid_i         = 1'b0;
            mem_data_i          = '0;
            m_tag[fa.index][way]   = fa.tag;
            m_valid[fa.index][way] = 1'b1;
            m_age[fa.index][way]   = 0;
        end
        wait_for(1'b0, "fetch response", cycles);
        if (timed_out) return;
        if (exp_hit) begin
            check_value("fetch_valid_o after accept", 64'(cycles), 64'd1);
            check_value("mem_read_o on hit", 64'(read_seen), 64'd0);
        end else begin
            // counting started in the cycle after the mem_valid_i pulse.
            check_value("fetch_valid_o after mem_valid_i", 64'(cycles + 1), 64'd2);
        end
        check_value("fetch_inst_o", 64'(fetch_inst_o), 64'(exp_inst));
        model_serve(fa.index, way);
        @(posedge clk);
        #1;
        fetch_req_i = 1'b0;
    endtask

    task automatic fence_all();
        if (timed_out) return;
        fence_i     = 1'b1;
        fetch_req_i = 1'b1;  // a request held through the fence must stay unserved.
        for (int c = 0; c < 70; c++) begin
            @(negedge clk);
            check_value("fetch_valid_o during fence", 64'(fetch_valid_o), 64'd0);
            check_value("mem_read_o during fence", 64'(mem_read_o), 64'd0);
            @(posedge clk);
            #1;
        end
        fence_i     = 1'b0;
        fetch_req_i = 1'b0;
        for (int s = 0; s < 64; s++) begin
            m_valid[s][0] = 1'b0;
            m_valid[s][1] = 1'b0;
        end
        @(posedge clk);  // one more edge to leave FENCE.
        #1;
    endtask

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        reset_i      = 1'b1;
        fetch_req_i  = 1'b0;
        fetch_addr_i = '0;
        mem_valid_i  = 1'b0;
        mem_data_i   = '0;
        fence_i      = 1'b0;
        n_checks     = 0;
        n_errors     = 0;
        n_timeouts   = 0;
        timed_out    = 1'b0;
        for (int s = 0; s < 64; s++) begin
            for (int w = 0; w < 2; w++) begin
                m_tag[s][w]   = '0;
                m_valid[s][w] = 1'b0;
                m_age[s][w]   = 0;
            end
        end
        repeat (3) @(posedge clk);
        #1;
        reset_i = 1'b0;
        @(negedge clk);
        check_value("fetch_valid_o after reset", 64'(fetch_valid_o), 64'd0);
        check_value("mem_read_o after reset", 64'(mem_read_o), 64'd0);
        @(posedge clk);
        #1;

        a = make_addr(TAG_BASE + 23'd1, 6'd9, 1'b0);
        b = make_addr(TAG_BASE + 23'd2, 6'd9, 1'b1);
        c = make_addr(TAG_BASE + 23'd3, 6'd9, 1'b0);
        fetch(make_addr(TAG_BASE, 6'd3, 1'b0));
        fetch(make_addr(TAG_BASE + 23'd7, 6'd45, 1'b1));
        fetch(make_addr(TAG_BASE, 6'd3, 1'b0));
        fetch(make_addr(TAG_BASE, 6'd3, 1'b1));
        fetch(make_addr(TAG_BASE + 23'd7, 6'd45, 1'b0));
        fetch(a);
        fetch(b);
        fetch(a);
        fetch(c);  // set 9 is full and b is the older way.
        fetch(a);
        fetch(b);
        fence_all();
        fetch(make_addr(TAG_BASE, 6'd3, 1'b1));
        fetch(make_addr(TAG_BASE + 23'd7, 6'd45, 1'b0));
        fetch(a);

        for (int n = 0; n < 200; n++) begin
            fetch(pool_addr());
            if (take_bits(1) != 0) begin
                @(posedge clk);
                #1;
            end
            if (n == 120) begin
                fence_all();
            end
        end

        $display("checks %0d, errors %0d, timeouts %0d", n_checks, n_errors, n_timeouts);
        if ((n_errors == 0) && (n_timeouts == 0)) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: sim.f
hw/icache_pkg.sv
hw/icache_ctrl.sv
hw/icache_tag_array.sv
hw/icache_data_array.sv
hw/icache_replace.sv
hw/icache_top.sv
test/icache_chk.sv
test/icache_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Compile and run the instruction cache simulation with Verilator.
set -eo pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module icache_tb \
    -f sim.f \
    -o icache_sim

./obj_dir/icache_sim 2>&1 | tee sim.log

if grep -q "tests failed" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi

echo "simulation finished without failure"
